// ==== source/busTermPkg.sv ====
/*
 * Bus termination package
 * Shared cycle-kind encoding, handshake payload structs and the
 * timing constants of the 68040 bus-cycle termination controller
 */

`default_nettype none

package busTermPkg;

    ////////////////////////////////////////
    // Cycle classification
    ////////////////////////////////////////

    // Which termination a bus cycle needs
    typedef enum logic [1:0] {
        irqAck    = 2'd0,
        romRead   = 2'd1,
        ciaAccess = 2'd2,
        unmapped  = 2'd3
    } cycleKindT;

    // Decoder to timers
    typedef struct packed {
        cycleKindT kind;
        logic      noCache;
    } cycleReqT;

    // Timers to driver, source is the kind that produced the termination
    typedef struct packed {
        cycleKindT source;
        logic      noCache;
    } termReqT;

    ////////////////////////////////////////
    // Timing in CLK80 cycles
    ////////////////////////////////////////

    // ROM setup delay, picked by the romDelay pin
    localparam logic [3:0] romDelayShort = 4'd5;
    localparam logic [3:0] romDelayLong  = 4'd8;

    // Autovector cycles carry no data so they end as fast as possible
    localparam logic [3:0] irqDelay = 4'd1;

    // Unmapped cycles end a bit after the longest CIA cycle
    localparam logic [7:0] watchdogDelay = 8'd249;

    // Acknowledge shape, low then driven high before release
    localparam logic [1:0] tackLowCycles     = 2'd2;
    localparam logic [1:0] tackReleaseCycles = 2'd1;

endpackage

`default_nettype wire

// ==== source/busTermIfs.sv ====
/*
 * Internal handshake interfaces
 * cycleReqIf carries classified cycles from the decoder to the timers,
 * termReqIf carries terminations from the timers to the acknowledge driver
 */

`default_nettype none

// Decoder to timers
interface cycleReqIf import busTermPkg::*; ();

    logic     valid;
    logic     ready;
    cycleReqT payload;

    // Source holds payload stable until valid and ready meet
    modport source (
        output valid,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// Timers to acknowledge driver
interface termReqIf import busTermPkg::*; ();

    logic    valid;
    logic    ready;
    termReqT payload;

    modport source (
        output valid,
        output payload,
        input  ready
    );

    // Ready comes from driver state only
    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

`default_nettype wire

// ==== source/cycleDecoder.sv ====
/*
 * Cycle decoder
 * Samples qualified 68040 transfer starts and sorts them by the
 * address-space strobes into one pending cycle request for the timers
 */

`default_nettype none

module cycleDecoder import busTermPkg::*; (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic tsN,
    input  logic phase40,
    input  logic romEn,
    input  logic ciaEnable,
    input  logic agnusSpace,
    input  logic autovector,
    input  logic rtcEnN,
    input  logic noCacheSpace,
    cycleReqIf.source req
);

    logic      startQual;
    logic      loadEn;
    cycleKindT kindNext;

    // Start is seen in the CLK40 high phase, Agnus cycles end elsewhere
    assign startQual = !tsN && phase40 && !agnusSpace;

    // Load only into an empty slot or one being handed over now
    assign loadEn = startQual && (!req.valid || req.ready);

    // Fixed priority, interrupt acknowledge and RTC first
    always_comb begin
        if (autovector || !rtcEnN) begin
            kindNext = irqAck;
        end else if (romEn) begin
            kindNext = romRead;
        end else if (ciaEnable) begin
            kindNext = ciaAccess;
        end else begin
            kindNext = unmapped;
        end
    end

    // Pending flag
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            req.valid <= 1'b0;
        end else if (loadEn) begin
            req.valid <= 1'b1;
        end else if (req.ready) begin
            req.valid <= 1'b0;
        end
    end

    // Request contents, taken at the sampling edge
    always_ff @(posedge CLK80) begin
        if (loadEn) begin
            req.payload.kind    <= kindNext;
            req.payload.noCache <= noCacheSpace;
        end
    end

    // Held request must not change while the timers are busy
    assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        req.valid && !req.ready |=> $stable(req.payload));

    // Only one request can wait, a further start would be lost
    assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        !(startQual && req.valid && !req.ready));

endmodule

`default_nettype wire

// ==== source/cycleTimers.sv ====
/*
 * Cycle termination timers
 * Times the termination of each accepted cycle by kind. One down counter
 * covers ROM setup, autovector and the unmapped-cycle watchdog. CIA cycles
 * wait for a falling edge of the synchronized peripheral clock. Also owns
 * the ROM enable for the length of a ROM cycle.
 */

`default_nettype none

module cycleTimers import busTermPkg::*; (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic phase40,
    input  logic romDelay,
    input  logic ciaClk,
    input  logic tackIn,
    input  logic agnusSpace,
    cycleReqIf.sink   req,
    termReqIf.source  term,
    output logic romEnN
);

    typedef enum logic [2:0] {
        tIdle    = 3'd0,
        tCount   = 3'd1,
        tCiaHigh = 3'd2,
        tCiaLow  = 3'd3,
        tTerm    = 3'd4
    } timerStateT;

    timerStateT state;
    logic [7:0] count;
    logic [7:0] delaySel;
    logic [1:0] ciaSync;
    cycleKindT  kind;
    logic       noCacheReg;
    logic       reqAccept;
    logic       termDone;
    logic       dropCycle;

    ////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////

    assign req.ready    = (state == tIdle);
    assign reqAccept    = req.valid && req.ready;
    assign term.valid   = (state == tTerm);
    assign termDone     = term.valid && term.ready;
    assign term.payload = '{source: kind, noCache: noCacheReg};

    // Someone else acknowledged the unmapped cycle, or Agnus took the bus
    assign dropCycle = (state == tCount) && (kind == unmapped) && (!tackIn || agnusSpace);

    // Delay until termination valid, counted from acceptance
    always_comb begin
        case (req.payload.kind)
            irqAck:  delaySel = {4'd0, irqDelay};
            romRead: delaySel = romDelay ? {4'd0, romDelayLong} : {4'd0, romDelayShort};
            default: delaySel = watchdogDelay;
        endcase
    end

    ////////////////////////////////////////
    // CIA clock synchronizer
    ////////////////////////////////////////

    // ciaSync[1] is the usable copy
    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            ciaSync <= 2'b00;
        end else begin
            ciaSync <= {ciaSync[0], ciaClk};
        end
    end

    ////////////////////////////////////////
    // Termination FSM
    ////////////////////////////////////////

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            state  <= tIdle;
            count  <= 8'd0;
            romEnN <= 1'b1;
        end else begin
            case (state)
                tIdle: begin
                    if (req.valid) begin
                        if (req.payload.kind == ciaAccess) begin
                            state <= tCiaHigh;
                        end else if (delaySel == 8'd1) begin
                            // Shortest case, valid on the next edge
                            state <= tTerm;
                        end else begin
                            state <= tCount;
                            count <= delaySel - 8'd1;
                        end
                        // ROM outputs open from acceptance on
                        if (req.payload.kind == romRead) begin
                            romEnN <= 1'b0;
                        end
                    end
                end
                tCount: begin
                    if (dropCycle) begin
                        state <= tIdle;
                    end else if (count == 8'd1) begin
                        state <= tTerm;
                    end else begin
                        count <= count - 8'd1;
                    end
                end
                // A full high phase first so a late start does not catch a stale edge
                tCiaHigh: begin
                    if (ciaSync[1]) begin
                        state <= tCiaLow;
                    end
                end
                // Falling edge seen, line up with the CLK40 low phase
                tCiaLow: begin
                    if (!ciaSync[1] && !phase40) begin
                        state <= tTerm;
                    end
                end
                tTerm: begin
                    if (term.ready) begin
                        state  <= tIdle;
                        romEnN <= 1'b1;
                    end
                end
                default: state <= tIdle;
            endcase
        end
    end

    // Cycle attributes for the termination payload
    always_ff @(posedge CLK80) begin
        if (reqAccept) begin
            kind       <= req.payload.kind;
            noCacheReg <= req.payload.noCache;
        end
    end

    // No second cycle is taken before the first one has ended
    assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        reqAccept |=> !reqAccept until_with (termDone || dropCycle));

    // ROM stays enabled while its termination waits on the driver
    assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        term.valid && (term.payload.source == romRead) |-> !romEnN);

endmodule

`default_nettype wire

// ==== source/tackDriver.sv ====
/*
 * Transfer acknowledge driver
 * Shapes each accepted termination into two low clocks and one high clock
 * on TA and TBI, with TCI added only for non-cacheable space
 */

`default_nettype none

module tackDriver import busTermPkg::*; (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    termReqIf.sink term,
    output logic tackN,
    output logic tbiN,
    output logic tciN,
    output logic tackOe,
    output logic tciOe
);

    typedef enum logic [1:0] {
        dIdle = 2'd0,
        dLow  = 2'd1,
        dHigh = 2'd2
    } driveStateT;

    driveStateT state;
    logic [1:0] cnt;
    logic       tackLevel;
    logic       noCacheReg;

    // Busy from acceptance until the pins are released
    assign term.ready = (state == dIdle);

    // No bursts here, so burst inhibit rides along with every acknowledge
    assign tackN = tackLevel;
    assign tbiN  = tackLevel;
    assign tciN  = tackLevel | !noCacheReg;
    assign tciOe = tackOe & noCacheReg;

    always_ff @(posedge CLK80 or posedge DELAYED_TACK_RST) begin
        if (DELAYED_TACK_RST) begin
            state     <= dIdle;
            cnt       <= 2'd0;
            tackLevel <= 1'b1;
            tackOe    <= 1'b0;
        end else begin
            case (state)
                dIdle: begin
                    if (term.valid) begin
                        state     <= dLow;
                        cnt       <= tackLowCycles;
                        tackLevel <= 1'b0;
                        tackOe    <= 1'b1;
                    end
                end
                // Drive high before letting go so the line does not float low
                dLow: begin
                    if (cnt == 2'd1) begin
                        state     <= dHigh;
                        cnt       <= tackReleaseCycles;
                        tackLevel <= 1'b1;
                    end else begin
                        cnt <= cnt - 2'd1;
                    end
                end
                dHigh: begin
                    if (cnt == 2'd1) begin
                        state  <= dIdle;
                        tackOe <= 1'b0;
                    end else begin
                        cnt <= cnt - 2'd1;
                    end
                end
                default: state <= dIdle;
            endcase
        end
    end

    // Cache inhibit choice for the cycle being acknowledged
    always_ff @(posedge CLK80) begin
        if (term.valid && term.ready) begin
            noCacheReg <= term.payload.noCache;
        end
    end

    // Acknowledge never stretches past its low window
    assert property (@(posedge CLK80) disable iff (DELAYED_TACK_RST)
        $fell(tackN) |-> ##tackLowCycles tackN);

endmodule

`default_nettype wire

// ==== source/busTermination.sv ====
/*
 * Bus termination controller, top level
 * Decoder, termination timers and acknowledge driver for 68040 cycles.
 * Tri-state pins appear as an active-low level plus an output enable.
 */

`default_nettype none

module busTermination (
    input  logic CLK80,
    input  logic DELAYED_TACK_RST,
    input  logic tsN,
    input  logic phase40,
    input  logic romEn,
    input  logic ciaEnable,
    input  logic agnusSpace,
    input  logic autovector,
    input  logic rtcEnN,
    input  logic noCacheSpace,
    input  logic romDelay,
    input  logic ciaClk,
    input  logic tackIn,
    output logic tackN,
    output logic tbiN,
    output logic tciN,
    output logic tackOe,
    output logic tciOe,
    output logic romEnN
);

    // Classified cycles, then terminations
    cycleReqIf cycleReqBus ();
    termReqIf  termReqBus ();

    cycleDecoder cycleDecoder_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .phase40          (phase40),
        .romEn            (romEn),
        .ciaEnable        (ciaEnable),
        .agnusSpace       (agnusSpace),
        .autovector       (autovector),
        .rtcEnN           (rtcEnN),
        .noCacheSpace     (noCacheSpace),
        .req              (cycleReqBus.source)
    );

    cycleTimers cycleTimers_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .phase40          (phase40),
        .romDelay         (romDelay),
        .ciaClk           (ciaClk),
        .tackIn           (tackIn),
        .agnusSpace       (agnusSpace),
        .req              (cycleReqBus.sink),
        .term             (termReqBus.source),
        .romEnN           (romEnN)
    );

    tackDriver tackDriver_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .term             (termReqBus.sink),
        .tackN            (tackN),
        .tbiN             (tbiN),
        .tciN             (tciN),
        .tackOe           (tackOe),
        .tciOe            (tciOe)
    );

endmodule

`default_nettype wire

// ==== verification/tbClock.sv ====
/*
 * Testbench clock and reset
 * CLK80 with a period of 8, reset held for 8 rising edges
 */

`default_nettype none

module tbClock (
    output logic CLK80,
    output logic DELAYED_TACK_RST
);

    initial begin
        CLK80 = 1'b0;
        forever begin
            #4 CLK80 = ~CLK80;
        end
    end

    // Rising reset edge after time zero so the async flops see it
    initial begin
        DELAYED_TACK_RST = 1'b0;
        #1 DELAYED_TACK_RST = 1'b1;
        repeat (8) @(posedge CLK80);
        #1 DELAYED_TACK_RST = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verification/tbChecker.sv ====
/*
 * Testbench checker
 * Watches the DUT pins, tracks started cycles in order and compares
 * acknowledge latency, shape, enables and ROM enable against expectations
 */

`default_nettype none

module tbChecker (
    input  logic        CLK80,
    input  logic        DELAYED_TACK_RST,
    input  logic        tsN,
    input  logic        phase40,
    input  logic        ciaClk,
    input  logic        tackN,
    input  logic        tbiN,
    input  logic        tciN,
    input  logic        tackOe,
    input  logic        tciOe,
    input  logic        romEnN,
    input  logic        expTerm,
    input  logic        expTci,
    input  logic        expRom,
    input  logic        expCia,
    input  logic [11:0] expLat,
    output int          errorCount
);

    int          edgeNow;
    int          lastCiaFall;
    int          shapeAge;
    bit          curTci;
    logic        prevTackN;
    logic        prevCia;
    logic        prevRomEnN;

    // Cycles waiting for their acknowledge, oldest first
    int          startQ[$];
    logic [11:0] latQ[$];
    bit          tciQ[$];
    bit          romQ[$];
    bit          ciaQ[$];

    initial begin
        errorCount  = 0;
        edgeNow     = 0;
        lastCiaFall = -1;
        shapeAge    = -1;
        curTci      = 1'b0;
        prevTackN   = 1'b1;
        prevCia     = 1'b0;
        prevRomEnN  = 1'b1;
    end

    task automatic compareBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic compareInt(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errorCount++;
            $display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////
    // Per-edge comparison
    ////////////////////////////////////////

    always @(posedge CLK80) begin : watch
        int          start;
        logic [11:0] lat;
        bit          isRom;
        bit          isCia;
        logic        expTack;

        if (DELAYED_TACK_RST) begin
            // Everything released and idle while in reset
            compareBit("tackOe", 1'b0, tackOe);
            compareBit("tciOe", 1'b0, tciOe);
            compareBit("romEnN", 1'b1, romEnN);
            compareBit("tackN", 1'b1, tackN);
            compareBit("tbiN", 1'b1, tbiN);
            compareBit("tciN", 1'b1, tciN);
        end else begin
            edgeNow++;
            if (prevCia && !ciaClk) begin
                lastCiaFall = edgeNow;
            end

            // Start sampled here, queued only when a termination is due
            if (!tsN && phase40 && expTerm) begin
                startQ.push_back(edgeNow);
                latQ.push_back(expLat);
                tciQ.push_back(expTci);
                romQ.push_back(expRom);
                ciaQ.push_back(expCia);
            end

            // Falling acknowledge ends the oldest cycle
            if (prevTackN && tackN === 1'b0) begin
                if (startQ.size() == 0) begin
                    errorCount++;
                    $display("error at %0t: acknowledge driven with no cycle pending", $time);
                    curTci = 1'b0;
                end else begin
                    start  = startQ.pop_front();
                    lat    = latQ.pop_front();
                    curTci = tciQ.pop_front();
                    isRom  = romQ.pop_front();
                    isCia  = ciaQ.pop_front();
                    // Zero latency marks the CIA case, no fixed timing
                    if (lat != 12'd0) begin
                        compareInt("acknowledge latency", int'(lat), edgeNow - start);
                    end
                    if (isRom) begin
                        compareBit("romEnN", 1'b1, romEnN);
                        compareBit("romEnN before acknowledge", 1'b0, prevRomEnN);
                    end
                    if (isCia) begin
                        compareBit("ciaClk", 1'b0, ciaClk);
                        if (lastCiaFall <= start) begin
                            errorCount++;
                            $display("error at %0t: CIA acknowledge came before a ciaClk fall",
                                $time);
                        end
                    end
                end
                shapeAge = 0;
            end else if (shapeAge >= 0) begin
                shapeAge++;
            end

            // Two low, one high, then released
            if (shapeAge >= 0 && shapeAge <= 2) begin
                expTack = (shapeAge == 2);
                compareBit("tackN", expTack, tackN);
                compareBit("tackOe", 1'b1, tackOe);
                compareBit("tciOe", curTci, tciOe);
                compareBit("tciN", !(curTci && shapeAge < 2), tciN);
            end else begin
                expTack = 1'b1;
                compareBit("tackN", expTack, tackN);
                compareBit("tackOe", 1'b0, tackOe);
                compareBit("tciOe", 1'b0, tciOe);
                compareBit("tciN", 1'b1, tciN);
                shapeAge = -1;
            end
            // Burst inhibit has the same shape as the acknowledge
            compareBit("tbiN", expTack, tbiN);
        end

        prevTackN  = tackN;
        prevCia    = ciaClk;
        prevRomEnN = romEnN;
    end

endmodule

`default_nettype wire

// ==== verification/tbBusTermination.sv ====
/*
 * Bus termination testbench
 * Reads cycles from the golden file, drives them into the DUT one clock
 * unit after the rising edge and leaves all comparing to the checker
 */

`default_nettype none

module tbBusTermination;

    localparam int maxLines    = 32;
    localparam int cycleBudget = 400;

    logic        CLK80;
    logic        DELAYED_TACK_RST;
    logic        tsN;
    logic        phase40;
    logic        romEn;
    logic        ciaEnable;
    logic        agnusSpace;
    logic        autovector;
    logic        rtcEnN;
    logic        noCacheSpace;
    logic        romDelay;
    logic        ciaClk;
    logic        tackIn;
    logic        tackN;
    logic        tbiN;
    logic        tciN;
    logic        tackOe;
    logic        tciOe;
    logic        romEnN;
    logic        expTerm;
    logic        expTci;
    logic        expRom;
    logic        expCia;
    logic [11:0] expLat;

    // kind, back, romDelay, noCache, agnus, foreign, term, latency, tci
    logic [43:0] golden [0:maxLines-1];
    int          lineCount;
    int          tbErrors;
    int          checkErrors;
    int          releases;
    int          outstanding;
    logic        prevOe;
    logic [3:0]  ciaDiv;
    logic [31:0] lcgState;

    tbClock clockGen (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST)
    );

    busTermination busTermination_i (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .phase40          (phase40),
        .romEn            (romEn),
        .ciaEnable        (ciaEnable),
        .agnusSpace       (agnusSpace),
        .autovector       (autovector),
        .rtcEnN           (rtcEnN),
        .noCacheSpace     (noCacheSpace),
        .romDelay         (romDelay),
        .ciaClk           (ciaClk),
        .tackIn           (tackIn),
        .tackN            (tackN),
        .tbiN             (tbiN),
        .tciN             (tciN),
        .tackOe           (tackOe),
        .tciOe            (tciOe),
        .romEnN           (romEnN)
    );

    tbChecker scoreboard (
        .CLK80            (CLK80),
        .DELAYED_TACK_RST (DELAYED_TACK_RST),
        .tsN              (tsN),
        .phase40          (phase40),
        .ciaClk           (ciaClk),
        .tackN            (tackN),
        .tbiN             (tbiN),
        .tciN             (tciN),
        .tackOe           (tackOe),
        .tciOe            (tciOe),
        .romEnN           (romEnN),
        .expTerm          (expTerm),
        .expTci           (expTci),
        .expRom           (expRom),
        .expCia           (expCia),
        .expLat           (expLat),
        .errorCount       (checkErrors)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // One clock, then CLK40 phase, CIA clock and release counting
    task automatic tick();
        @(posedge CLK80);
        #1;
        if (prevOe && !tackOe) begin
            releases++;
        end
        prevOe  = tackOe;
        phase40 = !phase40;
        ciaDiv  = ciaDiv + 4'd1;
        // CLK80 divided by 16
        ciaClk  = ciaDiv[3];
    endtask

    task automatic runLine(input int idx);
        logic [43:0] g;
        logic [3:0]  kind;
        logic [3:0]  foreign;
        bit          nextBack;
        int          gap;
        int          waited;

        g        = golden[idx];
        kind     = g[43:40];
        foreign  = g[23:20];
        nextBack = (idx + 1 < lineCount) && (golden[idx + 1][39:36] != 4'd0);

        // Random idle gap unless this start follows the previous one directly
        if (g[39:36] == 4'd0) begin
            lcgState = lcgNext(lcgState);
            gap = int'(lcgState[23:16] % 8'd6);
            repeat (gap) tick();
        end

        // Start must be sampled in the CLK40 high phase
        tick();
        while (!phase40) begin
            tick();
        end

        autovector   = (kind == 4'd0);
        rtcEnN       = !(kind == 4'd1);
        romEn        = (kind == 4'd2);
        ciaEnable    = (kind == 4'd3);
        romDelay     = g[32];
        noCacheSpace = g[28];
        agnusSpace   = g[24];
        expTerm      = g[16];
        expLat       = g[15:4];
        expTci       = g[0];
        expRom       = (kind == 4'd2);
        expCia       = (kind == 4'd3);
        tsN          = 1'b0;
        tick();

        // romDelay stays, the timers read it at acceptance
        tsN          = 1'b1;
        autovector   = 1'b0;
        rtcEnN       = 1'b1;
        romEn        = 1'b0;
        ciaEnable    = 1'b0;
        noCacheSpace = 1'b0;
        agnusSpace   = 1'b0;
        expTerm      = 1'b0;
        outstanding  = outstanding + int'(g[16]);

        // Foreign acknowledge or Agnus takeover during the watchdog count
        if (foreign != 4'd0) begin
            repeat (8) tick();
            tackIn     = (foreign != 4'd1);
            agnusSpace = (foreign == 4'd2);
            tick();
            tackIn     = 1'b1;
            agnusSpace = 1'b0;
        end

        if (g[16] == 1'b0) begin
            // Long enough for the watchdog to have fired by mistake
            repeat (260) tick();
        end else if (!nextBack) begin
            waited = 0;
            while (releases < outstanding && waited < cycleBudget) begin
                tick();
                waited++;
            end
            if (releases < outstanding) begin
                tbErrors++;
                $display("timeout at %0t: line %0d got no acknowledge release", $time, idx);
                outstanding = releases;
            end
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        tsN          = 1'b1;
        phase40      = 1'b0;
        romEn        = 1'b0;
        ciaEnable    = 1'b0;
        agnusSpace   = 1'b0;
        autovector   = 1'b0;
        rtcEnN       = 1'b1;
        noCacheSpace = 1'b0;
        romDelay     = 1'b0;
        ciaClk       = 1'b0;
        tackIn       = 1'b1;
        expTerm      = 1'b0;
        expTci       = 1'b0;
        expRom       = 1'b0;
        expCia       = 1'b0;
        expLat       = 12'd0;
        lineCount    = 0;
        tbErrors     = 0;
        releases     = 0;
        outstanding  = 0;
        prevOe       = 1'b0;
        ciaDiv       = 4'd0;
        lcgState     = 32'd52962;

        // Entries past the end of the file keep kind F and their own index
        for (int i = 0; i < maxLines; i++) begin
            golden[i] = {4'hF, 40'(i)};
        end
        $readmemh("verification/busTermGolden.txt", golden);
        for (int i = 0; i < maxLines; i++) begin
            if (golden[i][43:40] != 4'hF) begin
                lineCount = i + 1;
            end
        end
        if (lineCount == 0) begin
            tbErrors++;
            $display("no cycles could be read from the golden file");
        end

        @(negedge DELAYED_TACK_RST);
        repeat (4) tick();
        for (int i = 0; i < lineCount; i++) begin
            runLine(i);
        end
        repeat (4) tick();

        $display("Error counts: checker %0d, testbench %0d", checkErrors, tbErrors);
        if (checkErrors + tbErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit grows with the number of cycles in the file
    initial begin
        wait (lineCount > 0);
        repeat (lineCount * cycleBudget) @(posedge CLK80);
        tbErrors++;
        $display("timeout: run did not end within %0d cycles", lineCount * cycleBudget);
        $display("Error counts: checker %0d, testbench %0d", checkErrors, tbErrors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/busTermGolden.txt ====
// kind(0 av,1 rtc,2 rom,3 cia,4 unmapped)_back_romDelay_noCache_agnus_foreign
// _expTerm_expLatency(edges from start to TA low, 0 = CIA)_expTci
0_0_0_0_0_0_1_003_0
0_0_0_1_0_0_1_003_1
1_0_0_0_0_0_1_003_0
2_0_0_0_0_0_1_007_0
2_0_1_0_0_0_1_00A_0
2_0_1_1_0_0_1_00A_1
3_0_0_0_0_0_1_000_0
3_0_0_1_0_0_1_000_1
4_0_0_0_0_0_1_0FB_0
4_0_0_1_0_0_1_0FB_1
4_0_0_0_0_1_0_000_0
4_0_0_0_0_2_0_000_0
4_0_0_0_1_0_0_000_0
0_0_0_0_0_0_1_003_0
0_1_0_0_0_0_1_005_0
0_0_0_1_0_0_1_003_1
2_1_0_0_0_0_1_007_0
2_0_0_0_0_0_1_007_0
0_1_0_1_0_0_1_009_1
3_0_0_1_0_0_1_000_1
2_0_1_0_0_0_1_00A_0
0_0_0_1_0_0_1_003_1

// ==== sources.f ====
source/busTermPkg.sv
source/busTermIfs.sv
source/cycleDecoder.sv
source/cycleTimers.sv
source/tackDriver.sv
source/busTermination.sv
verification/tbClock.sv
verification/tbChecker.sv
verification/tbBusTermination.sv

// ==== Makefile ====
# Verilator simulation of the bus termination controller

VERILATOR ?= verilator
TOP       ?= tbBusTermination
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sources.f
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
